//--- src/atri_pkt_pkg.sv
package atri_pkt_pkg;

	// Stream and field types
	typedef logic [7:0] byte_t;
	typedef logic [7:0] dest_t;
	typedef logic [1:0] i2c_chan_t;
	typedef logic [7:0] err_code_t;

	// Framing characters '<' and '>'
	localparam byte_t SOF_BYTE = 8'h3C;
	localparam byte_t EOF_BYTE = 8'h3E;

	// Destination and source codes
	localparam dest_t DEST_CONTROLLER = 8'd0;
	localparam dest_t DEST_WISHBONE   = 8'd1;
	localparam dest_t DEST_DBSTATUS   = 8'd2;
	localparam dest_t DEST_I2C_FIRST  = 8'd3;
	localparam dest_t DEST_I2C_LAST   = 8'd6;

	// Error payloads
	localparam err_code_t ERR_RESET      = 8'h00;
	localparam err_code_t ERR_BAD_PACKET = 8'hFF;
	localparam err_code_t ERR_BAD_DEST   = 8'hFE;
	localparam err_code_t ERR_I2C_FULL   = 8'hFD;

	// Payload lengths of the replies
	localparam byte_t STATUS_LEN = 8'd4;
	localparam byte_t ERR_LEN    = 8'd1;

	localparam int NUM_DAUGHTERS = 4;

	typedef enum logic [1:0] {
		REPLY_ERR,
		REPLY_STATUS
	} reply_kind_t;

	// Parser to framer request
	typedef struct packed {
		reply_kind_t kind;
		byte_t       pktno;
		err_code_t   err;
	} reply_req_t;

endpackage

//--- src/rx_parser.sv
`timescale 1ns/1ps

module rx_parser (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  atri_pkt_pkg::byte_t      dat_i,
	input  logic                     empty_i,
	input  logic                     rx_enable_i,
	input  atri_pkt_pkg::byte_t      i2c_count_i,
	output logic                     rd_o,
	output logic                     i2c_wr_o,
	output atri_pkt_pkg::i2c_chan_t  i2c_adr_o,
	output atri_pkt_pkg::byte_t      i2c_dat_o,
	output logic                     reply_valid_o,
	output atri_pkt_pkg::reply_req_t reply_o
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_START,
		S_DEST,
		S_NUMBER,
		S_LENGTH,
		S_I2C_CHECK,
		S_FWD_NUMBER,
		S_FWD_LENGTH,
		S_FWD_PAYLOAD,
		S_STATUS_END,
		S_I2C_END,
		S_REPORT
	} state_t;

	state_t                   state_q;
	atri_pkt_pkg::byte_t      pktno_q;
	atri_pkt_pkg::byte_t      len_q;
	atri_pkt_pkg::byte_t      cnt_q;
	atri_pkt_pkg::i2c_chan_t  chan_q;
	logic                     status_q;
	atri_pkt_pkg::reply_req_t reply_q;

	function automatic atri_pkt_pkg::reply_req_t err_reply(input atri_pkt_pkg::err_code_t code);
		atri_pkt_pkg::reply_req_t r;
		r.kind  = atri_pkt_pkg::REPLY_ERR;
		r.pktno = '0;
		r.err   = code;
		return r;
	endfunction

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (rx_enable_i && !empty_i)
						state_q <= S_START;
				end
				S_START: begin
					if (empty_i || dat_i != atri_pkt_pkg::SOF_BYTE) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
						state_q <= S_REPORT;
					end else begin
						state_q <= S_DEST;
					end
				end
				S_DEST: begin
					if (empty_i) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
						state_q <= S_REPORT;
					end else if (dat_i == atri_pkt_pkg::DEST_CONTROLLER ||
							dat_i == atri_pkt_pkg::DEST_WISHBONE ||
							dat_i > atri_pkt_pkg::DEST_I2C_LAST) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_DEST);
						state_q <= S_REPORT;
					end else begin
						status_q <= (dat_i == atri_pkt_pkg::DEST_DBSTATUS);
						// Unused for a status request
						chan_q <= atri_pkt_pkg::i2c_chan_t'(dat_i - atri_pkt_pkg::DEST_I2C_FIRST);
						state_q <= S_NUMBER;
					end
				end
				S_NUMBER: begin
					if (empty_i) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
						state_q <= S_REPORT;
					end else begin
						pktno_q <= dat_i;
						state_q <= status_q ? S_STATUS_END : S_LENGTH;
					end
				end
				S_LENGTH: begin
					if (empty_i) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
						state_q <= S_REPORT;
					end else begin
						len_q <= dat_i;
						cnt_q <= '0;
						state_q <= S_I2C_CHECK;
					end
				end
				S_I2C_CHECK: begin
					if (len_q > i2c_count_i) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_I2C_FULL);
						state_q <= S_REPORT;
					end else begin
						state_q <= S_FWD_NUMBER;
					end
				end
				S_FWD_NUMBER: state_q <= S_FWD_LENGTH;
				S_FWD_LENGTH: state_q <= (len_q == '0) ? S_I2C_END : S_FWD_PAYLOAD;
				S_FWD_PAYLOAD: begin
					if (empty_i) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
						state_q <= S_REPORT;
					end else begin
						cnt_q <= cnt_q + 8'd1;
						if (cnt_q == len_q - 8'd1)
							state_q <= S_I2C_END;
					end
				end
				S_STATUS_END: begin
					if (empty_i || dat_i != atri_pkt_pkg::EOF_BYTE) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
					end else begin
						reply_q.kind  <= atri_pkt_pkg::REPLY_STATUS;
						reply_q.pktno <= pktno_q;
						reply_q.err   <= atri_pkt_pkg::ERR_RESET;
					end
					state_q <= S_REPORT;
				end
				S_I2C_END: begin
					if (empty_i || dat_i != atri_pkt_pkg::EOF_BYTE) begin
						reply_q <= err_reply(atri_pkt_pkg::ERR_BAD_PACKET);
						state_q <= S_REPORT;
					end else begin
						state_q <= S_IDLE;
					end
				end
				// Wait out an unsolicited status packet before handing over
				S_REPORT: begin
					if (rx_enable_i)
						state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Every examined byte is popped in the same cycle
	always_comb begin
		case (state_q)
			S_START, S_DEST, S_NUMBER, S_LENGTH,
			S_FWD_PAYLOAD, S_STATUS_END, S_I2C_END: rd_o = !empty_i;
			default: rd_o = 1'b0;
		endcase
	end

	always_comb begin
		case (state_q)
			S_FWD_NUMBER: begin
				i2c_wr_o  = 1'b1;
				i2c_dat_o = pktno_q;
			end
			S_FWD_LENGTH: begin
				i2c_wr_o  = 1'b1;
				i2c_dat_o = len_q;
			end
			S_FWD_PAYLOAD: begin
				i2c_wr_o  = !empty_i;
				i2c_dat_o = dat_i;
			end
			default: begin
				i2c_wr_o  = 1'b0;
				i2c_dat_o = dat_i;
			end
		endcase
	end

	assign i2c_adr_o     = chan_q;
	assign reply_valid_o = (state_q == S_REPORT) && rx_enable_i;
	assign reply_o       = reply_q;

endmodule

//--- src/tx_framer.sv
`timescale 1ns/1ps

module tx_framer (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     full_i,
	input  logic                     reply_valid_i,
	input  atri_pkt_pkg::reply_req_t reply_i,
	input  logic                     status_change_i,
	input  atri_pkt_pkg::byte_t [atri_pkt_pkg::NUM_DAUGHTERS-1:0] db_status_i,
	output atri_pkt_pkg::byte_t      dat_o,
	output logic                     wr_o,
	output logic                     packet_o,
	output logic                     status_change_ack_o,
	output logic                     rx_enable_o
);

	typedef enum logic [2:0] {
		S_RESET_ANN,
		S_IDLE,
		S_START,
		S_SOURCE,
		S_NUMBER,
		S_LENGTH,
		S_PAYLOAD,
		S_END
	} state_t;

	state_t                    state_q;
	atri_pkt_pkg::reply_kind_t kind_q;
	atri_pkt_pkg::dest_t       src_q;
	atri_pkt_pkg::byte_t       num_q;
	atri_pkt_pkg::byte_t       len_q;
	atri_pkt_pkg::byte_t       idx_q;
	atri_pkt_pkg::err_code_t   err_q;
	atri_pkt_pkg::byte_t       payload;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			// Header of the reset announcement
			state_q <= S_RESET_ANN;
			kind_q  <= atri_pkt_pkg::REPLY_ERR;
			src_q   <= atri_pkt_pkg::DEST_CONTROLLER;
			num_q   <= '0;
			len_q   <= atri_pkt_pkg::ERR_LEN;
			err_q   <= atri_pkt_pkg::ERR_RESET;
			idx_q   <= '0;
		end else begin
			case (state_q)
				S_RESET_ANN, S_START: begin
					if (!full_i)
						state_q <= S_SOURCE;
				end
				S_IDLE: begin
					idx_q <= '0;
					if (status_change_i) begin
						kind_q  <= atri_pkt_pkg::REPLY_STATUS;
						src_q   <= atri_pkt_pkg::DEST_DBSTATUS;
						num_q   <= '0;
						len_q   <= atri_pkt_pkg::STATUS_LEN;
						state_q <= S_START;
					end else if (reply_valid_i) begin
						kind_q <= reply_i.kind;
						if (reply_i.kind == atri_pkt_pkg::REPLY_STATUS) begin
							src_q <= atri_pkt_pkg::DEST_DBSTATUS;
							num_q <= reply_i.pktno;
							len_q <= atri_pkt_pkg::STATUS_LEN;
						end else begin
							src_q <= atri_pkt_pkg::DEST_CONTROLLER;
							num_q <= '0;
							len_q <= atri_pkt_pkg::ERR_LEN;
							err_q <= reply_i.err;
						end
						state_q <= S_START;
					end
				end
				S_SOURCE: if (!full_i) state_q <= S_NUMBER;
				S_NUMBER: if (!full_i) state_q <= S_LENGTH;
				S_LENGTH: if (!full_i) state_q <= S_PAYLOAD;
				S_PAYLOAD: begin
					if (!full_i) begin
						idx_q <= idx_q + 8'd1;
						if (idx_q == len_q - 8'd1)
							state_q <= S_END;
					end
				end
				S_END: if (!full_i) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Daughter 1 sits in the low byte
	assign payload = (kind_q == atri_pkt_pkg::REPLY_STATUS) ?
		db_status_i[atri_pkt_pkg::i2c_chan_t'(idx_q)] : err_q;

	always_comb begin
		case (state_q)
			S_SOURCE:  dat_o = src_q;
			S_NUMBER:  dat_o = num_q;
			S_LENGTH:  dat_o = len_q;
			S_PAYLOAD: dat_o = payload;
			S_END:     dat_o = atri_pkt_pkg::EOF_BYTE;
			default:   dat_o = atri_pkt_pkg::SOF_BYTE;
		endcase
	end

	// Byte held in place while the outbound FIFO is full
	assign wr_o     = !reset_i && (state_q != S_IDLE) && !full_i;
	assign packet_o = (state_q == S_END) && !full_i;

	assign status_change_ack_o = (state_q == S_IDLE) && status_change_i;
	assign rx_enable_o         = (state_q == S_IDLE) && !status_change_i;

endmodule

//--- src/atri_packet_ctrl.sv
`timescale 1ns/1ps

module atri_packet_ctrl (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  atri_pkt_pkg::byte_t     dat_i,
	input  logic                    empty_i,
	input  logic                    full_i,
	input  logic                    status_change_i,
	input  atri_pkt_pkg::byte_t [atri_pkt_pkg::NUM_DAUGHTERS-1:0] db_status_i,
	input  atri_pkt_pkg::byte_t     i2c_count_i,
	output atri_pkt_pkg::byte_t     dat_o,
	output logic                    rd_o,
	output logic                    wr_o,
	output logic                    packet_o,
	output logic                    status_change_ack_o,
	output logic                    i2c_wr_o,
	output atri_pkt_pkg::i2c_chan_t i2c_adr_o,
	output atri_pkt_pkg::byte_t     i2c_dat_o
);

	atri_pkt_pkg::reply_req_t reply_req;
	logic                     reply_valid;
	logic                     rx_enable;

	// Inbound side
	rx_parser rx_parser_i (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.dat_i         (dat_i),
		.empty_i       (empty_i),
		.rx_enable_i   (rx_enable),
		.i2c_count_i   (i2c_count_i),
		.rd_o          (rd_o),
		.i2c_wr_o      (i2c_wr_o),
		.i2c_adr_o     (i2c_adr_o),
		.i2c_dat_o     (i2c_dat_o),
		.reply_valid_o (reply_valid),
		.reply_o       (reply_req)
	);

	// Outbound side
	tx_framer tx_framer_i (
		.clk_i               (clk_i),
		.reset_i             (reset_i),
		.full_i              (full_i),
		.reply_valid_i       (reply_valid),
		.reply_i             (reply_req),
		.status_change_i     (status_change_i),
		.db_status_i         (db_status_i),
		.dat_o               (dat_o),
		.wr_o                (wr_o),
		.packet_o            (packet_o),
		.status_change_ack_o (status_change_ack_o),
		.rx_enable_o         (rx_enable)
	);

endmodule

//--- verif/atri_packet_ctrl_sva.sv
`timescale 1ns/1ps

module atri_packet_ctrl_sva (
	input logic                clk_i,
	input logic                reset_i,
	input logic                full_i,
	input logic                empty_i,
	input logic                wr_o,
	input logic                rd_o,
	input logic                packet_o,
	input logic                status_change_ack_o,
	input atri_pkt_pkg::byte_t dat_o
);

	wr_not_full: assert property (@(posedge clk_i) disable iff (reset_i) wr_o |-> !full_i)
		else $error("wr_o high while the outbound FIFO is full");

	rd_not_empty: assert property (@(posedge clk_i) disable iff (reset_i) rd_o |-> !empty_i)
		else $error("rd_o high while the inbound FIFO is empty");

	// End of packet marks the write of the end byte
	packet_on_eof: assert property (@(posedge clk_i) disable iff (reset_i)
		packet_o |-> (wr_o && dat_o == atri_pkt_pkg::EOF_BYTE))
		else $error("packet_o high without a write of the end byte");

	ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
		status_change_ack_o |=> !status_change_ack_o)
		else $error("status_change_ack_o held for more than one cycle");

endmodule

//--- verif/atri_packet_ctrl_tb.sv
`timescale 1ns/1ps

module atri_packet_ctrl_tb;

	typedef struct packed {
		atri_pkt_pkg::i2c_chan_t chan;
		atri_pkt_pkg::byte_t     data;
	} i2c_write_t;

	localparam int RESET_CYCLES = 10;
	localparam int NUM_TESTS    = 9;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + 200 * NUM_TESTS) * 10;

	logic                    clk_i;
	logic                    reset_i;
	logic                    empty_i;
	logic                    full_i;
	logic                    status_change_i;
	atri_pkt_pkg::byte_t     dat_i;
	atri_pkt_pkg::byte_t     i2c_count_i;
	atri_pkt_pkg::byte_t [atri_pkt_pkg::NUM_DAUGHTERS-1:0] db_status_i;
	atri_pkt_pkg::byte_t     dat_o;
	logic                    rd_o;
	logic                    wr_o;
	logic                    packet_o;
	logic                    status_change_ack_o;
	logic                    i2c_wr_o;
	atri_pkt_pkg::i2c_chan_t i2c_adr_o;
	atri_pkt_pkg::byte_t     i2c_dat_o;

	atri_pkt_pkg::byte_t in_q[$];
	atri_pkt_pkg::byte_t stage_q[$];
	atri_pkt_pkg::byte_t out_q[$];
	atri_pkt_pkg::byte_t exp_q[$];
	i2c_write_t          i2c_q[$];
	i2c_write_t          exp_i2c[$];

	int    errors;
	int    checks;
	int    pkt_cnt;
	int    exp_pkts;
	int    ack_cnt;
	logic  pop_s;
	string test_name;

	always #5 clk_i = ~clk_i;

	atri_packet_ctrl atri_packet_ctrl_i (.*);

	bind atri_packet_ctrl atri_packet_ctrl_sva atri_packet_ctrl_sva_i (
		.clk_i               (clk_i),
		.reset_i             (reset_i),
		.full_i              (full_i),
		.empty_i             (empty_i),
		.wr_o                (wr_o),
		.rd_o                (rd_o),
		.packet_o            (packet_o),
		.status_change_ack_o (status_change_ack_o),
		.dat_o               (dat_o)
	);

	// Expected byte idx of a status reply (9 bytes) or an error reply (6 bytes)
	function automatic atri_pkt_pkg::byte_t ref_byte(input logic is_status,
			input atri_pkt_pkg::byte_t num, input atri_pkt_pkg::byte_t code, input int idx);
		int last;
		last = is_status ? 8 : 5;
		if (idx == 0)
			return atri_pkt_pkg::SOF_BYTE;
		if (idx == last)
			return atri_pkt_pkg::EOF_BYTE;
		case (idx)
			1: return is_status ? 8'd2 : 8'd0;
			2: return is_status ? num : 8'd0;
			3: return is_status ? 8'd4 : 8'd1;
			default: return is_status ? db_status_i[idx-4] : code;
		endcase
	endfunction

	task automatic expect_reply(input logic is_status, input atri_pkt_pkg::byte_t num,
			input atri_pkt_pkg::byte_t code);
		for (int i = 0; i < (is_status ? 9 : 6); i++)
			exp_q.push_back(ref_byte(is_status, num, code, i));
		exp_pkts++;
	endtask

	task automatic expect_i2c(input int dest, input atri_pkt_pkg::byte_t data);
		i2c_write_t w;
		w.chan = atri_pkt_pkg::i2c_chan_t'(dest - 3);
		w.data = data;
		exp_i2c.push_back(w);
	endtask

	task automatic start_test(input string name, input atri_pkt_pkg::byte_t count);
		@(posedge clk_i);
		#1;
		test_name = name;
		i2c_count_i = count;
		for (int i = 0; i < atri_pkt_pkg::NUM_DAUGHTERS; i++)
			db_status_i[i] = atri_pkt_pkg::byte_t'($urandom);
	endtask

	// Whole packets enter the inbound FIFO at once
	task automatic send_staged();
		@(negedge clk_i);
		while (stage_q.size() > 0)
			in_q.push_back(stage_q.pop_front());
	endtask

	task automatic wait_done();
		while (exp_q.size() != 0 || exp_i2c.size() != 0)
			@(posedge clk_i);
	endtask

	task automatic raise_status_change();
		int acks_before;
		acks_before = ack_cnt;
		@(posedge clk_i);
		#1 status_change_i = 1'b1;
		while (ack_cnt == acks_before)
			@(posedge clk_i);
		#1 status_change_i = 1'b0;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_i) begin
		pop_s = rd_o && !reset_i;
		if (reset_i) begin
			assert (!(wr_o || rd_o || i2c_wr_o || packet_o || status_change_ack_o)) else begin
				$display("A strobe output was high while reset was asserted");
				errors++;
			end
		end else begin
			if (wr_o)
				out_q.push_back(dat_o);
			if (packet_o)
				pkt_cnt++;
			if (status_change_ack_o)
				ack_cnt++;
			if (i2c_wr_o)
				i2c_q.push_back({i2c_adr_o, i2c_dat_o});
		end
	end

	// FIFO models
	always @(posedge clk_i) begin
		#1;
		if (pop_s)
			void'(in_q.pop_front());
		empty_i = (in_q.size() == 0);
		dat_i = empty_i ? 8'h00 : in_q[0];
		full_i = ($urandom_range(2, 0) == 0);
	end

	always @(posedge clk_i) begin : compare
		atri_pkt_pkg::byte_t got_b;
		atri_pkt_pkg::byte_t want_b;
		i2c_write_t          got_w;
		i2c_write_t          want_w;
		while (out_q.size() > 0) begin
			got_b = out_q.pop_front();
			assert (exp_q.size() > 0) else begin
				$display("Outbound byte %h arrived in %s when no reply was expected",
					got_b, test_name);
				errors++;
			end
			if (exp_q.size() > 0) begin
				want_b = exp_q.pop_front();
				checks++;
				assert (got_b == want_b) else begin
					$display("ERR %s: expected %h, actual %h", test_name, want_b, got_b);
					errors++;
				end
			end
		end
		while (i2c_q.size() > 0) begin
			got_w = i2c_q.pop_front();
			assert (exp_i2c.size() > 0) else begin
				$display("I2C write %h arrived in %s when none was expected", got_w, test_name);
				errors++;
			end
			if (exp_i2c.size() > 0) begin
				want_w = exp_i2c.pop_front();
				checks++;
				assert (got_w == want_w) else begin
					$display("ERR %s: expected %h, actual %h", test_name, want_w, got_w);
					errors++;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the DUT did not finish the tests in time");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int                  acks_before;
		atri_pkt_pkg::byte_t num;
		atri_pkt_pkg::byte_t len;
		atri_pkt_pkg::byte_t b;
		void'($urandom(32'h3749));
		clk_i = 1'b0;
		reset_i = 1'b1;
		empty_i = 1'b1;
		full_i = 1'b0;
		status_change_i = 1'b0;
		dat_i = '0;
		i2c_count_i = '0;
		db_status_i = '0;
		errors = 0;
		checks = 0;
		pkt_cnt = 0;
		exp_pkts = 0;
		ack_cnt = 0;
		pop_s = 1'b0;
		test_name = "reset_announce";
		expect_reply(1'b0, 8'h00, 8'h00);
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1 reset_i = 1'b0;
		wait_done();

		start_test("status_request", 8'd0);
		stage_q = '{atri_pkt_pkg::SOF_BYTE, 8'd2, 8'hA5, atri_pkt_pkg::EOF_BYTE};
		expect_reply(1'b1, 8'hA5, 8'h00);
		send_staged();
		wait_done();

		start_test("status_change", 8'd0);
		acks_before = ack_cnt;
		expect_reply(1'b1, 8'h00, 8'h00);
		raise_status_change();
		wait_done();
		assert (ack_cnt == acks_before + 1) else begin
			$display("ERR %s: expected %0d, actual %0d", test_name, acks_before + 1, ack_cnt);
			errors++;
		end

		// One packet per daughter and a final status request as the only reply
		start_test("i2c_forward", 8'd16);
		for (int dest = 3; dest <= 6; dest++) begin
			num = atri_pkt_pkg::byte_t'($urandom);
			len = atri_pkt_pkg::byte_t'($urandom_range(8, 1));
			stage_q.push_back(atri_pkt_pkg::SOF_BYTE);
			stage_q.push_back(atri_pkt_pkg::byte_t'(dest));
			stage_q.push_back(num);
			stage_q.push_back(len);
			expect_i2c(dest, num);
			expect_i2c(dest, len);
			for (int i = 0; i < len; i++) begin
				b = atri_pkt_pkg::byte_t'($urandom);
				stage_q.push_back(b);
				expect_i2c(dest, b);
			end
			stage_q.push_back(atri_pkt_pkg::EOF_BYTE);
		end
		stage_q.push_back(atri_pkt_pkg::SOF_BYTE);
		stage_q.push_back(8'd2);
		stage_q.push_back(8'h5A);
		stage_q.push_back(atri_pkt_pkg::EOF_BYTE);
		expect_reply(1'b1, 8'h5A, 8'h00);
		send_staged();
		wait_done();

		start_test("i2c_full", 8'd2);
		stage_q = '{atri_pkt_pkg::SOF_BYTE, 8'd4, 8'h11, 8'd5};
		expect_reply(1'b0, 8'h00, 8'hFD);
		send_staged();
		wait_done();

		start_test("bad_dest_1", 8'd16);
		stage_q = '{atri_pkt_pkg::SOF_BYTE, 8'd1};
		expect_reply(1'b0, 8'h00, 8'hFE);
		send_staged();
		wait_done();

		start_test("bad_dest_7", 8'd16);
		stage_q = '{atri_pkt_pkg::SOF_BYTE, 8'd7};
		expect_reply(1'b0, 8'h00, 8'hFE);
		send_staged();
		wait_done();

		start_test("bad_end", 8'd16);
		stage_q = '{atri_pkt_pkg::SOF_BYTE, 8'd2, 8'h33, 8'h00};
		expect_reply(1'b0, 8'h00, 8'hFF);
		send_staged();
		wait_done();

		start_test("stray_byte", 8'd16);
		stage_q = '{8'h55};
		expect_reply(1'b0, 8'h00, 8'hFF);
		send_staged();
		wait_done();

		test_name = "packet_count";
		assert (pkt_cnt == exp_pkts) else begin
			$display("ERR %s: expected %0d, actual %0d", test_name, exp_pkts, pkt_cnt);
			errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- atri_packet_ctrl.f
src/atri_pkt_pkg.sv
src/rx_parser.sv
src/tx_framer.sv
src/atri_packet_ctrl.sv
verif/atri_packet_ctrl_sva.sv
verif/atri_packet_ctrl_tb.sv

//--- Bender.yml
package:
  name: atri_packet_ctrl

sources:
  - src/atri_pkt_pkg.sv
  - src/rx_parser.sv
  - src/tx_framer.sv
  - src/atri_packet_ctrl.sv
  - target: test
    files:
      - verif/atri_packet_ctrl_sva.sv
      - verif/atri_packet_ctrl_tb.sv
